/* logic/copy_pkg.sv */
`default_nettype none

package copy_pkg;

    // widths of the SDRAM address and data buses
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // byte step between two consecutive words in memory
    localparam logic [addr_w-1:0] word_bytes = addr_w'(4);

    // word offsets of the CPU slave registers
    localparam logic [3:0] reg_ctrl  = 4'd0;
    localparam logic [3:0] reg_dst   = 4'd1;
    localparam logic [3:0] reg_src   = 4'd2;
    localparam logic [3:0] reg_count = 4'd3;

    // request from the CPU into the register slave
    typedef struct packed {
        logic [3:0]        address;
        logic              read;
        logic              write;
        logic [data_w-1:0] writedata;
    } cpu_req_t;

    // response from the register slave back to the CPU
    // readdata is valid one cycle after an accepted read
    typedef struct packed {
        logic              waitrequest;
        logic [data_w-1:0] readdata;
    } cpu_rsp_t;

    // request from the copy engine out to the SDRAM
    typedef struct packed {
        logic [addr_w-1:0] address;
        logic              read;
        logic              write;
        logic [data_w-1:0] writedata;
    } mem_req_t;

    // response from the SDRAM with pipelined read data
    typedef struct packed {
        logic              waitrequest;
        logic [data_w-1:0] readdata;
        logic              readdatavalid;
    } mem_rsp_t;

    // one copy job as programmed by the CPU
    typedef struct packed {
        logic [addr_w-1:0] dst;
        logic [addr_w-1:0] src;
        logic [data_w-1:0] count;
    } copy_job_t;

endpackage

`default_nettype wire

/* logic/copy_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module copy_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  copy_pkg::cpu_req_t            cpu_req,
    output copy_pkg::cpu_rsp_t            cpu_rsp,
    output copy_pkg::copy_job_t           job,
    output logic                          start,
    input  logic                          busy,
    input  logic                          done,
    input  logic [copy_pkg::data_w-1:0]   words_done
);
    import copy_pkg::*;

    // programmed job, handed to the engine which latches it on start
    copy_job_t         job_q;
    // start pulse, registered one cycle after the control write is seen
    logic              start_q;
    // a job launched from the CPU side that has not reported done yet
    logic              pending_q;
    // high for the single cycle after done, in which the stalled write is let through
    logic              release_q;
    logic [data_w-1:0] rdata_q;
    logic              ctrl_write;
    logic              launch;
    logic              cfg_write;

    // a write to the control offset, still held by the CPU
    assign ctrl_write = cpu_req.write && (cpu_req.address == reg_ctrl);

    // only a fresh control write from an idle engine launches a job
    // the same write is then held until release and must not launch twice
    assign launch = ctrl_write && !pending_q && !release_q && !busy;

    // job registers only take new values between jobs
    assign cfg_write = cpu_req.write && !ctrl_write && !busy && !pending_q;

    // the control write stalls from its first cycle on
    // it is accepted in the cycle after done, when release_q opens the gate
    assign cpu_rsp.waitrequest = ctrl_write && !release_q;
    assign cpu_rsp.readdata    = rdata_q;

    assign job   = job_q;
    assign start = start_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_q   <= 1'b0;
            pending_q <= 1'b0;
            release_q <= 1'b0;
        end else begin
            start_q   <= launch;
            release_q <= done && pending_q;
            if (launch) begin
                pending_q <= 1'b1;
            end else if (done) begin
                pending_q <= 1'b0;
            end
        end
    end

    // decode of the configuration writes at offsets 1 to 3
    always_ff @(posedge clk) begin
        if (cfg_write) begin
            case (cpu_req.address)
                reg_dst:   job_q.dst   <= cpu_req.writedata;
                reg_src:   job_q.src   <= cpu_req.writedata;
                reg_count: job_q.count <= cpu_req.writedata;
                default:   ;
            endcase
        end
    end

    // reads never stall and return data one cycle later
    // offset 0 reports progress of the running or last job
    always_ff @(posedge clk) begin
        if (cpu_req.read) begin
            case (cpu_req.address)
                reg_ctrl:  rdata_q <= words_done;
                reg_dst:   rdata_q <= job_q.dst;
                reg_src:   rdata_q <= job_q.src;
                reg_count: rdata_q <= job_q.count;
                default:   rdata_q <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/copy_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module copy_engine (
    input  logic                          clk,
    input  logic                          rst_n,
    input  copy_pkg::copy_job_t           job,
    input  logic                          start,
    output logic                          busy,
    output logic                          done,
    output logic [copy_pkg::data_w-1:0]   words_done,
    output copy_pkg::mem_req_t            mem_req,
    input  copy_pkg::mem_rsp_t            mem_rsp
);
    import copy_pkg::*;

    // one word in flight at a time
    // read it, wait for its data, write it back out, then move on
    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_wait,
        st_write,
        st_next
    } state_t;

    state_t            state_q;
    logic [addr_w-1:0] src_q;
    logic [addr_w-1:0] dst_q;
    logic [data_w-1:0] remaining_q;
    logic [data_w-1:0] words_done_q;
    // word captured from the read, held stable while the write waits
    logic [data_w-1:0] data_q;
    logic              load;
    logic              rd_data;
    logic              wr_accept;

    assign load      = (state_q == st_idle) && start;
    assign rd_data   = (state_q == st_wait) && mem_rsp.readdatavalid;
    assign wr_accept = (state_q == st_write) && !mem_rsp.waitrequest;

    // master outputs come straight from the state and registered addresses
    // so they stay put for as long as waitrequest holds them
    assign mem_req.read      = (state_q == st_read);
    assign mem_req.write     = (state_q == st_write);
    assign mem_req.address   = (state_q == st_write) ? dst_q : src_q;
    assign mem_req.writedata = data_q;

    assign busy       = (state_q != st_idle);
    // st_next lasts exactly one cycle, which makes done a pulse
    assign done       = (state_q == st_next);
    assign words_done = words_done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= st_idle;
            remaining_q  <= '0;
            words_done_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (start) begin
                        remaining_q  <= job.count;
                        words_done_q <= '0;
                        // an empty job goes straight to the finish
                        state_q      <= (job.count == '0) ? st_next : st_read;
                    end
                end
                st_read: begin
                    if (!mem_rsp.waitrequest) begin
                        state_q <= st_wait;
                    end
                end
                st_wait: begin
                    if (mem_rsp.readdatavalid) begin
                        state_q <= st_write;
                    end
                end
                st_write: begin
                    if (!mem_rsp.waitrequest) begin
                        remaining_q  <= remaining_q - data_w'(1);
                        words_done_q <= words_done_q + data_w'(1);
                        // the following read is raised in the very next cycle
                        state_q      <= (remaining_q == data_w'(1)) ? st_next : st_read;
                    end
                end
                st_next: begin
                    state_q <= st_idle;
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // address and data path
    always_ff @(posedge clk) begin
        if (load) begin
            src_q <= job.src;
            dst_q <= job.dst;
        end else if (wr_accept) begin
            src_q <= src_q + word_bytes;
            dst_q <= dst_q + word_bytes;
        end
        if (rd_data) begin
            data_q <= mem_rsp.readdata;
        end
    end

endmodule

`default_nettype wire

/* logic/copy_dma_top.sv */
`timescale 1ns/1ps
`default_nettype none

module copy_dma_top (
    input  logic                clk,
    input  logic                rst_n,
    input  copy_pkg::cpu_req_t  cpu_req,
    output copy_pkg::cpu_rsp_t  cpu_rsp,
    output copy_pkg::mem_req_t  mem_req,
    input  copy_pkg::mem_rsp_t  mem_rsp
);
    import copy_pkg::*;

    // job handoff from the register block to the engine
    copy_job_t         job;
    logic              start;
    // status going back from the engine
    logic              busy;
    logic              done;
    logic [data_w-1:0] words_done;

    // the CPU side programs the job and waits on the start write
    copy_regs copy_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .job        (job),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .words_done (words_done)
    );

    // the SDRAM side moves the words one at a time
    copy_engine copy_engine_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .job        (job),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .words_done (words_done),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

endmodule

`default_nettype wire

/* testbench/sdram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  logic               clk,
    input  logic               rst_n,
    input  copy_pkg::mem_req_t mem_req,
    output copy_pkg::mem_rsp_t mem_rsp
);
    import copy_pkg::*;

    // 4 KB of word storage, indexed by the word address bits
    logic [data_w-1:0] mem [1024];
    logic [31:0]       lfsr_q;
    logic              stall_q;
    // one read in flight, counting down its random latency
    logic              pending_q;
    logic [1:0]        delay_q;
    logic [data_w-1:0] rdata_q;
    logic              rvalid_q;

    assign mem_rsp.waitrequest   = stall_q;
    assign mem_rsp.readdata      = rdata_q;
    assign mem_rsp.readdatavalid = rvalid_q;

    // galois form of x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // backdoor access for preload and for checking the memory contents
    task automatic load_word(input logic [addr_w-1:0] addr, input logic [data_w-1:0] word);
        mem[addr[11:2]] = word;
    endtask

    function automatic logic [data_w-1:0] peek_word(input logic [addr_w-1:0] addr);
        return mem[addr[11:2]];
    endfunction

    always @(posedge clk) begin : model_step
        logic [31:0] s;
        logic [1:0]  lat;
        if (!rst_n) begin
            lfsr_q    <= 32'h6238;
            stall_q   <= 1'b0;
            pending_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            s = lfsr_q;
            rvalid_q <= 1'b0;
            if (pending_q) begin
                if (delay_q == 2'd0) begin
                    rvalid_q  <= 1'b1;
                    pending_q <= 1'b0;
                end else begin
                    delay_q <= delay_q - 2'd1;
                end
            end
            // requests are taken only in a cycle without waitrequest
            if (mem_req.write && !stall_q) begin
                mem[mem_req.address[11:2]] <= mem_req.writedata;
            end
            if (mem_req.read && !stall_q) begin
                rdata_q   <= mem[mem_req.address[11:2]];
                lat[0] = s[0];
                s = lfsr_next(s);
                lat[1] = s[0];
                s = lfsr_next(s);
                delay_q   <= lat;
                pending_q <= 1'b1;
            end
            // the stall for the next cycle, drawn whether or not a request is up
            stall_q <= s[0];
            lfsr_q  <= lfsr_next(s);
        end
    end

endmodule

`default_nettype wire

/* testbench/copy_dma_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module copy_dma_tb;
    import copy_pkg::*;

    localparam int reset_cycles = 16;

    logic     clk;
    logic     rst_n;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    // expected memory contents, updated by the testbench for every job
    logic [data_w-1:0] shadow [1024];
    logic [addr_w-1:0] job_src [$];
    logic [addr_w-1:0] job_dst [$];
    logic [data_w-1:0] job_cnt [$];
    int errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int mem_writes = 0;
    int cycles = 0;
    // grows by 40 plus 12 per word for every job in the test data
    int cycle_limit = reset_cycles + 40;

    copy_dma_top copy_dma_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    sdram_model sdram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watch the master port and bound the length of the run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (mem_req.read && mem_req.write) begin
            $display("master read and write were high in the same cycle");
            errors++;
        end
        if (rst_n && mem_req.write && !mem_rsp.waitrequest) begin
            mem_writes <= mem_writes + 1;
        end
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the jobs did not finish", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // background for words that the test data leaves alone
    function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] addr);
        return ~addr ^ {addr[15:0], addr[31:16]};
    endfunction

    task automatic check_word(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_readdata(input logic [3:0] offset, input cpu_rsp_t rsp,
                                  input logic [data_w-1:0] exp);
        if (rsp.readdata !== exp) begin
            $display("FAIL cpu_rsp.readdata at offset %0d: got %h, expected %h",
                     offset, rsp.readdata, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic load_testdata();
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("testbench/copy_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/copy_testdata.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] == "M") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                    if (n != 2) begin
                        $display("a memory record in the test data could not be read");
                        errors++;
                    end else begin
                        shadow[a[11:2]] = b;
                        sdram_i.load_word(a, b);
                    end
                end else if (line.len() > 1 && line[0] == "J") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
                    if (n != 3) begin
                        $display("a job record in the test data could not be read");
                        errors++;
                    end else begin
                        job_src.push_back(a);
                        job_dst.push_back(b);
                        job_cnt.push_back(c);
                        cycle_limit += 40 + 12 * c;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_reg(input logic [3:0] offset, input logic [data_w-1:0] data);
        @(posedge clk);
        cpu_req <= {offset, 1'b0, 1'b1, data};
        do @(posedge clk); while (cpu_rsp.waitrequest);
        cpu_req <= '0;
    endtask

    // readdata belongs to the cycle after the read, so it is sampled one edge later
    task automatic read_check(input logic [3:0] offset, input logic [data_w-1:0] exp);
        @(posedge clk);
        cpu_req <= {offset, 1'b1, 1'b0, 32'h0};
        @(posedge clk);
        cpu_req <= '0;
        @(posedge clk);
        check_readdata(offset, cpu_rsp, exp);
    endtask

    // the start write is done once it is seen high and unstalled in the same cycle
    task automatic start_and_wait(output int held);
        logic accepted;
        held = 0;
        accepted = 1'b0;
        @(posedge clk);
        cpu_req <= {reg_ctrl, 1'b0, 1'b1, 32'h0};
        while (!accepted) begin
            @(posedge clk);
            held++;
            accepted = cpu_req.write && cpu_req.address == reg_ctrl && !cpu_rsp.waitrequest;
        end
        cpu_req <= '0;
    endtask

    // cuts into the held start write with config writes, then puts it back
    task automatic disturb_config();
        int off;
        repeat (4) @(posedge clk);
        for (off = 1; off <= 3; off++) begin
            cpu_req <= {off[3:0], 1'b0, 1'b1, 32'hbad0_0000 + off};
            @(posedge clk);
        end
        cpu_req <= {reg_ctrl, 1'b0, 1'b1, 32'h0};
    endtask

    task automatic run_job(input int idx);
        logic [addr_w-1:0] src;
        logic [addr_w-1:0] dst;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] cnt;
        int                k;
        int                held;
        int                start_errors;
        int                writes_before;
        src = job_src[idx];
        dst = job_dst[idx];
        cnt = job_cnt[idx];
        start_errors = errors;
        write_reg(reg_dst, dst);
        write_reg(reg_src, src);
        write_reg(reg_count, cnt);
        read_check(reg_dst, dst);
        read_check(reg_src, src);
        read_check(reg_count, cnt);
        writes_before = mem_writes;
        fork
            start_and_wait(held);
            if (idx == 0) disturb_config();
        join
        for (k = 0; k < cnt; k++) begin
            shadow[dst[11:2] + k] = shadow[src[11:2] + k];
        end
        // the copied range plus one word on either side of it
        for (k = -1; k <= int'(cnt); k++) begin
            addr = dst + 4 * k;
            check_word($sformatf("mem[%h]", addr), sdram_i.peek_word(addr), shadow[addr[11:2]]);
        end
        if (cnt == 0) begin
            check_word("master writes", mem_writes - writes_before, 32'h0);
        end
        // progress counter and an untouched job after the release
        read_check(reg_ctrl, cnt);
        read_check(reg_dst, dst);
        read_check(reg_src, src);
        read_check(reg_count, cnt);
        tests++;
        if (errors != start_errors) failed_tests++;
        $display("test job %0d: %0d words, start held %0d cycles, %s",
                 idx, cnt, held, (errors == start_errors) ? "ok" : "FAIL");
    endtask

    initial begin : main
        int i;
        cpu_req = '0;
        rst_n = 1'b0;
        for (i = 0; i < 1024; i++) begin
            shadow[i] = fill_word(i * 4);
            sdram_i.load_word(i * 4, shadow[i]);
        end
        load_testdata();
        repeat (reset_cycles) @(posedge clk);
        check_flag("mem_req.read", mem_req.read, 1'b0);
        check_flag("mem_req.write", mem_req.write, 1'b0);
        check_flag("cpu_rsp.waitrequest", cpu_rsp.waitrequest, 1'b0);
        rst_n <= 1'b1;
        tests++;
        if (errors != 0) failed_tests++;
        $display("test reset: %s", (errors == 0) ? "ok" : "FAIL");
        for (i = 0; i < job_src.size(); i++) begin
            run_job(i);
        end
        $display("%0d tests, %0d failed, %0d failed checks", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/copy_testdata.txt */
# M <address> <word>                   preload one memory word, hex
# J <source> <destination> <count>     run one copy job, hex
M 00000100 3c0ffee1
M 00000104 a5a55a5a
M 00000108 00000000
M 0000010c ffffffff
M 00000110 12345678
M 00000114 87654321
M 00000118 deadbeef
M 0000011c 0badf00d
M 00000200 11110001
M 00000204 22220002
M 00000208 33330003
M 0000020c 44440004
M 00000210 55550005
M 00000140 c0c0c0c0
M 00000144 7e7e7e7e
J 00000100 00000400 00000008
J 00000200 00000500 00000005
J 00000300 00000600 00000000
J 00000140 00000700 00000003
J 00000400 00000800 00000004

/* list.f */
logic/copy_pkg.sv
logic/copy_regs.sv
logic/copy_engine.sv
logic/copy_dma_top.sv
testbench/sdram_model.sv
testbench/copy_dma_tb.sv

/* Bender.yml */
package:
  name: copy_dma

sources:
  - logic/copy_pkg.sv
  - logic/copy_regs.sv
  - logic/copy_engine.sv
  - logic/copy_dma_top.sv
  - target: simulation
    files:
      - testbench/sdram_model.sv
      - testbench/copy_dma_tb.sv
